// File: rtl/mips_isa_pkg.sv
package mips_isa_pkg;

    // field positions within a 32-bit instruction word
    localparam int op_lsb    = 26;
    localparam int rs_lsb    = 21;
    localparam int rt_lsb    = 16;
    localparam int rd_lsb    = 11;
    localparam int shamt_lsb = 6;

    // field widths
    localparam int op_w     = 6;
    localparam int func_w   = 6;
    localparam int reg_w    = 5;
    localparam int shamt_w  = 5;
    localparam int imm_w    = 16;
    localparam int target_w = 26;

    // primary opcodes
    localparam logic [op_w-1:0] op_rtype = 6'h00;
    localparam logic [op_w-1:0] op_j     = 6'h02;
    localparam logic [op_w-1:0] op_beq   = 6'h04;
    localparam logic [op_w-1:0] op_bne   = 6'h05;
    localparam logic [op_w-1:0] op_addiu = 6'h09;
    localparam logic [op_w-1:0] op_andi  = 6'h0c;
    localparam logic [op_w-1:0] op_ori   = 6'h0d;
    localparam logic [op_w-1:0] op_lui   = 6'h0f;
    localparam logic [op_w-1:0] op_lw    = 6'h23;
    localparam logic [op_w-1:0] op_sw    = 6'h2b;

    // function codes for op_rtype
    localparam logic [func_w-1:0] fn_sll  = 6'h00;
    localparam logic [func_w-1:0] fn_srl  = 6'h02;
    localparam logic [func_w-1:0] fn_jr   = 6'h08;
    localparam logic [func_w-1:0] fn_addu = 6'h21;
    localparam logic [func_w-1:0] fn_subu = 6'h23;
    localparam logic [func_w-1:0] fn_and  = 6'h24;
    localparam logic [func_w-1:0] fn_or   = 6'h25;
    localparam logic [func_w-1:0] fn_slt  = 6'h2a;

    localparam int reg_count = 32;

endpackage

// File: rtl/core_bus_pkg.sv
package core_bus_pkg;

    // data and address width of the memory bus
    localparam int word_w = 32;

    // multicycle step of the core
    typedef enum logic [1:0] {
        st_halt  = 2'd0,
        st_fetch = 2'd1,
        st_exec  = 2'd2,
        st_mem   = 2'd3
    } cycle_t;

    // address of the first instruction
    localparam logic [word_w-1:0] reset_pc = 32'h0000_0000;

endpackage

// File: rtl/instr_reg.sv
`timescale 1ns/1ps

module instr_reg (
    input  logic                                  clk,
    input  logic                                  reset,
    input  core_bus_pkg::cycle_t                  state,
    input  logic [core_bus_pkg::word_w-1:0]       readdata,
    input  logic                                  mem_done,
    output logic [mips_isa_pkg::op_w-1:0]         op,
    output logic [mips_isa_pkg::reg_w-1:0]        rs,
    output logic [mips_isa_pkg::reg_w-1:0]        rt,
    output logic [mips_isa_pkg::reg_w-1:0]        rd,
    output logic [mips_isa_pkg::shamt_w-1:0]      shamt,
    output logic [mips_isa_pkg::func_w-1:0]       func,
    output logic [mips_isa_pkg::imm_w-1:0]        immediate,
    output logic [mips_isa_pkg::target_w-1:0]     target
);

    // stored instruction
    logic [core_bus_pkg::word_w-1:0] instr;
    // word that the fields are taken from
    logic [core_bus_pkg::word_w-1:0] word;
    logic                            capture;

    // fetch completes when the bus drops waitrequest
    assign capture = (state == core_bus_pkg::st_fetch) && mem_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (capture) begin
            instr <= readdata;
        end
    end

    // incoming word goes straight through during the capture cycle
    assign word = capture ? readdata : instr;

    assign op        = word[mips_isa_pkg::op_lsb    +: mips_isa_pkg::op_w];
    assign rs        = word[mips_isa_pkg::rs_lsb    +: mips_isa_pkg::reg_w];
    assign rt        = word[mips_isa_pkg::rt_lsb    +: mips_isa_pkg::reg_w];
    assign rd        = word[mips_isa_pkg::rd_lsb    +: mips_isa_pkg::reg_w];
    assign shamt     = word[mips_isa_pkg::shamt_lsb +: mips_isa_pkg::shamt_w];
    // func, immediate and target all start at bit zero
    assign func      = word[mips_isa_pkg::func_w-1:0];
    assign immediate = word[mips_isa_pkg::imm_w-1:0];
    assign target    = word[mips_isa_pkg::target_w-1:0];

    // execute only ever follows a completed fetch
    a_instr_fresh: assert property (
        @(posedge clk) disable iff (reset)
        (state == core_bus_pkg::st_exec) |-> $past(capture)
    ) else $error("execute entered without a freshly captured instruction");

endmodule

// File: rtl/cycle_ctrl.sv
`timescale 1ns/1ps

module cycle_ctrl (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              waitrequest,
    input  logic                              is_mem,
    input  logic                              is_store,
    input  logic                              halt_req,
    input  logic [core_bus_pkg::word_w-1:0]   pc,
    input  logic [core_bus_pkg::word_w-1:0]   data_address,
    input  logic [core_bus_pkg::word_w-1:0]   store_data,
    output core_bus_pkg::cycle_t              state,
    output logic                              mem_done,
    output logic [core_bus_pkg::word_w-1:0]   address,
    output logic                              read,
    output logic                              write,
    output logic [core_bus_pkg::word_w-1:0]   writedata,
    output logic                              active
);

    core_bus_pkg::cycle_t state_next;
    // set once the program has ended, so st_halt is left only by reset
    logic                 halted;
    logic                 strobe;

    always_comb begin
        state_next = state;
        case (state)
            core_bus_pkg::st_halt: begin
                if (!halted) begin
                    state_next = core_bus_pkg::st_fetch;
                end
            end
            core_bus_pkg::st_fetch: begin
                if (mem_done) begin
                    state_next = core_bus_pkg::st_exec;
                end
            end
            core_bus_pkg::st_exec: begin
                if (halt_req) begin
                    state_next = core_bus_pkg::st_halt;
                end else if (is_mem) begin
                    state_next = core_bus_pkg::st_mem;
                end else begin
                    state_next = core_bus_pkg::st_fetch;
                end
            end
            default: begin
                if (mem_done) begin
                    state_next = core_bus_pkg::st_fetch;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= core_bus_pkg::st_halt;
            halted <= 1'b0;
        end else begin
            state <= state_next;
            if (state == core_bus_pkg::st_exec && halt_req) begin
                halted <= 1'b1;
            end
        end
    end

    // bus strobes follow the step directly
    assign read   = (state == core_bus_pkg::st_fetch)
                 || (state == core_bus_pkg::st_mem && !is_store);
    assign write  = (state == core_bus_pkg::st_mem) && is_store;
    assign strobe = read || write;

    assign mem_done  = strobe && !waitrequest;
    assign address   = (state == core_bus_pkg::st_mem) ? data_address : pc;
    assign writedata = write ? store_data : '0;
    assign active    = (state != core_bus_pkg::st_halt);

    // a store that skips the memory step would be lost
    a_store_is_mem: assert property (
        @(posedge clk) disable iff (reset)
        (state == core_bus_pkg::st_exec && is_store) |-> is_mem
    ) else $error("store not marked as a memory access");

    a_bus_held: assert property (
        @(posedge clk) disable iff (reset)
        (strobe && waitrequest) |=>
            ($stable(address) && $stable(writedata) && $stable(read) && $stable(write))
    ) else $error("bus changed while waitrequest was high");

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [mips_isa_pkg::reg_w-1:0]    rs,
    input  logic [mips_isa_pkg::reg_w-1:0]    rt,
    input  logic                              wr_en,
    input  logic [mips_isa_pkg::reg_w-1:0]    wr_reg,
    input  logic [core_bus_pkg::word_w-1:0]   wr_data,
    output logic [core_bus_pkg::word_w-1:0]   rs_value,
    output logic [core_bus_pkg::word_w-1:0]   rt_value
);

    logic [core_bus_pkg::word_w-1:0] regs [mips_isa_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mips_isa_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_reg != '0) begin
            // writes to register zero are dropped
            regs[wr_reg] <= wr_data;
        end
    end

    // asynchronous reads, register zero always reads zero
    assign rs_value = (rs == '0) ? '0 : regs[rs];
    assign rt_value = (rt == '0) ? '0 : regs[rt];

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                                  clk,
    input  logic                                  reset,
    input  core_bus_pkg::cycle_t                  state,
    input  logic                                  mem_done,
    input  logic [mips_isa_pkg::op_w-1:0]         op,
    input  logic [mips_isa_pkg::reg_w-1:0]        rs,
    input  logic [mips_isa_pkg::reg_w-1:0]        rt,
    input  logic [mips_isa_pkg::reg_w-1:0]        rd,
    input  logic [mips_isa_pkg::shamt_w-1:0]      shamt,
    input  logic [mips_isa_pkg::func_w-1:0]       func,
    input  logic [mips_isa_pkg::imm_w-1:0]        immediate,
    input  logic [mips_isa_pkg::target_w-1:0]     target,
    input  logic [core_bus_pkg::word_w-1:0]       rs_value,
    input  logic [core_bus_pkg::word_w-1:0]       rt_value,
    input  logic [core_bus_pkg::word_w-1:0]       readdata,
    output logic [core_bus_pkg::word_w-1:0]       pc,
    output logic [core_bus_pkg::word_w-1:0]       data_address,
    output logic [core_bus_pkg::word_w-1:0]       store_data,
    output logic                                  is_mem,
    output logic                                  is_store,
    output logic                                  halt_req,
    output logic                                  wr_en,
    output logic [mips_isa_pkg::reg_w-1:0]        wr_reg,
    output logic [core_bus_pkg::word_w-1:0]       wr_data
);

    logic [core_bus_pkg::word_w-1:0] imm_sext;
    logic [core_bus_pkg::word_w-1:0] imm_zext;
    logic [core_bus_pkg::word_w-1:0] pc_plus4;
    logic [core_bus_pkg::word_w-1:0] pc_next;
    logic [core_bus_pkg::word_w-1:0] alu_result;
    logic                            alu_writes;
    logic                            is_rtype;
    logic                            is_jr;
    logic                            taken;

    assign imm_sext = {{(core_bus_pkg::word_w - mips_isa_pkg::imm_w){immediate[15]}}, immediate};
    assign imm_zext = {{(core_bus_pkg::word_w - mips_isa_pkg::imm_w){1'b0}}, immediate};
    assign is_rtype = (op == mips_isa_pkg::op_rtype);
    assign is_jr    = is_rtype && (func == mips_isa_pkg::fn_jr);

    // ALU, alu_writes marks instructions that write back from execute
    always_comb begin
        alu_result = '0;
        alu_writes = 1'b1;
        case (op)
            mips_isa_pkg::op_rtype: begin
                case (func)
                    mips_isa_pkg::fn_addu: alu_result = rs_value + rt_value;
                    mips_isa_pkg::fn_subu: alu_result = rs_value - rt_value;
                    mips_isa_pkg::fn_and:  alu_result = rs_value & rt_value;
                    mips_isa_pkg::fn_or:   alu_result = rs_value | rt_value;
                    mips_isa_pkg::fn_slt:  alu_result = {31'd0, $signed(rs_value) < $signed(rt_value)};
                    mips_isa_pkg::fn_sll:  alu_result = rt_value << shamt;
                    mips_isa_pkg::fn_srl:  alu_result = rt_value >> shamt;
                    default:               alu_writes = 1'b0;
                endcase
            end
            mips_isa_pkg::op_addiu: alu_result = rs_value + imm_sext;
            mips_isa_pkg::op_andi:  alu_result = rs_value & imm_zext;
            mips_isa_pkg::op_ori:   alu_result = rs_value | imm_zext;
            mips_isa_pkg::op_lui:   alu_result = {immediate, 16'h0000};
            default:                alu_writes = 1'b0;
        endcase
    end

    // branches take effect directly, no delay slot
    assign taken = ((op == mips_isa_pkg::op_beq) && (rs_value == rt_value))
                || ((op == mips_isa_pkg::op_bne) && (rs_value != rt_value));
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (is_jr) begin
            pc_next = rs_value;
        end else if (op == mips_isa_pkg::op_j) begin
            pc_next = {pc_plus4[31:28], target, 2'b00};
        end else if (taken) begin
            pc_next = pc_plus4 + (imm_sext << 2);
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= core_bus_pkg::reset_pc;
        end else if (state == core_bus_pkg::st_exec) begin
            pc <= pc_next;
        end
    end

    assign data_address = rs_value + imm_sext;
    assign store_data   = rt_value;
    assign is_store     = (op == mips_isa_pkg::op_sw);
    assign is_mem       = is_store || (op == mips_isa_pkg::op_lw);
    // jr to address zero ends the program
    assign halt_req     = is_jr && (rs_value == '0);

    // write-back, ALU results in execute, load data when the read completes
    assign wr_en   = ((state == core_bus_pkg::st_exec) && alu_writes)
                  || ((state == core_bus_pkg::st_mem) && mem_done
                      && (op == mips_isa_pkg::op_lw));
    assign wr_reg  = is_rtype ? rd : rt;
    assign wr_data = (state == core_bus_pkg::st_mem) ? readdata : alu_result;

endmodule

// File: rtl/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [core_bus_pkg::word_w-1:0]   readdata,
    input  logic                              waitrequest,
    output logic [core_bus_pkg::word_w-1:0]   address,
    output logic                              read,
    output logic                              write,
    output logic [core_bus_pkg::word_w-1:0]   writedata,
    output logic                              active
);

    core_bus_pkg::cycle_t                state;
    logic                                mem_done;

    // decoded fields
    logic [mips_isa_pkg::op_w-1:0]       op;
    logic [mips_isa_pkg::reg_w-1:0]      rs;
    logic [mips_isa_pkg::reg_w-1:0]      rt;
    logic [mips_isa_pkg::reg_w-1:0]      rd;
    logic [mips_isa_pkg::shamt_w-1:0]    shamt;
    logic [mips_isa_pkg::func_w-1:0]     func;
    logic [mips_isa_pkg::imm_w-1:0]      immediate;
    logic [mips_isa_pkg::target_w-1:0]   target;

    // execute unit to controller and register file
    logic [core_bus_pkg::word_w-1:0]     pc;
    logic [core_bus_pkg::word_w-1:0]     data_address;
    logic [core_bus_pkg::word_w-1:0]     store_data;
    logic                                is_mem;
    logic                                is_store;
    logic                                halt_req;
    logic                                wr_en;
    logic [mips_isa_pkg::reg_w-1:0]      wr_reg;
    logic [core_bus_pkg::word_w-1:0]     wr_data;
    logic [core_bus_pkg::word_w-1:0]     rs_value;
    logic [core_bus_pkg::word_w-1:0]     rt_value;

    instr_reg u_instr_reg (
        .clk(clk), .reset(reset), .state(state), .readdata(readdata),
        .mem_done(mem_done), .op(op), .rs(rs), .rt(rt), .rd(rd),
        .shamt(shamt), .func(func), .immediate(immediate), .target(target)
    );

    cycle_ctrl u_cycle_ctrl (
        .clk(clk), .reset(reset), .waitrequest(waitrequest),
        .is_mem(is_mem), .is_store(is_store), .halt_req(halt_req),
        .pc(pc), .data_address(data_address), .store_data(store_data),
        .state(state), .mem_done(mem_done), .address(address),
        .read(read), .write(write), .writedata(writedata), .active(active)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .rs(rs), .rt(rt),
        .wr_en(wr_en), .wr_reg(wr_reg), .wr_data(wr_data),
        .rs_value(rs_value), .rt_value(rt_value)
    );

    exec_unit u_exec_unit (
        .clk(clk), .reset(reset), .state(state), .mem_done(mem_done),
        .op(op), .rs(rs), .rt(rt), .rd(rd), .shamt(shamt), .func(func),
        .immediate(immediate), .target(target),
        .rs_value(rs_value), .rt_value(rt_value), .readdata(readdata),
        .pc(pc), .data_address(data_address), .store_data(store_data),
        .is_mem(is_mem), .is_store(is_store), .halt_req(halt_req),
        .wr_en(wr_en), .wr_reg(wr_reg), .wr_data(wr_data)
    );

endmodule

// File: sim/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    localparam int mem_words    = 256;
    localparam int prog_base    = 'h10;
    localparam int store_base   = 'h80;
    localparam int period       = 100;
    localparam int quiet_cycles = 20;

    logic                            clk;
    logic                            reset;
    logic [core_bus_pkg::word_w-1:0] readdata;
    logic                            waitrequest;
    logic [core_bus_pkg::word_w-1:0] address;
    logic                            read;
    logic                            write;
    logic [core_bus_pkg::word_w-1:0] writedata;
    logic                            active;

    // image of the test file and the memory behind the bus
    logic [31:0] tests [0:255];
    logic [31:0] mem [0:mem_words-1];
    logic [31:0] lcg_state;
    logic        loaded;
    int          prog_len;
    int          store_count;
    int          stores_seen;
    int          value_errors;
    int          other_errors;
    int          watchdog_cycles;

    // open transfer and the bus values seen when it started
    logic        waiting;
    int          stall_left;
    logic [31:0] held_address;
    logic [31:0] held_writedata;
    logic        held_read;
    logic        held_write;

    mips_core dut (
        .clk(clk), .reset(reset), .readdata(readdata), .waitrequest(waitrequest),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .active(active)
    );

    always #(period / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // compare a completed write with the next expected pair
    task automatic check_store();
        logic [31:0] exp_address;
        logic [31:0] exp_data;
        if (stores_seen >= store_count) begin
            other_errors++;
            $display("extra store of %h to address %h after the last expected one",
                     writedata, address);
        end else begin
            exp_address = tests[store_base + 2 * stores_seen];
            exp_data    = tests[store_base + 2 * stores_seen + 1];
            if (address !== exp_address) begin
                value_errors++;
                $display("mismatch address: store %0d got %h expected %h",
                         stores_seen, address, exp_address);
            end
            if (writedata !== exp_data) begin
                value_errors++;
                $display("mismatch writedata: store %0d got %h expected %h",
                         stores_seen, writedata, exp_data);
            end
        end
        stores_seen++;
    endtask

    task automatic check_held();
        if (address !== held_address) begin
            value_errors++;
            $display("mismatch address: changed during stall, got %h expected %h",
                     address, held_address);
        end
        if (writedata !== held_writedata) begin
            value_errors++;
            $display("mismatch writedata: changed during stall, got %h expected %h",
                     writedata, held_writedata);
        end
        if (read !== held_read || write !== held_write) begin
            other_errors++;
            $display("read or write strobe changed while waitrequest was high");
        end
    endtask

    // waitrequest goes low now, so the next rising edge completes the transfer
    task automatic finish_transfer();
        waitrequest = 1'b0;
        waiting     = 1'b0;
        if (write) begin
            check_store();
        end
        if (address >= mem_words * 4 || address[1:0] != 2'b00) begin
            other_errors++;
            $display("bus address %h is outside the memory or not word aligned", address);
        end else if (write) begin
            mem[address[9:2]] = writedata;
        end else begin
            readdata = mem[address[9:2]];
        end
    endtask

    // memory model with random stalls
    always @(negedge clk) begin
        if (reset) begin
            waitrequest = 1'b1;
            waiting     = 1'b0;
        end else if (read || write) begin
            if (read && write) begin
                other_errors++;
                $display("read and write are high together");
            end
            if (waiting) begin
                check_held();
            end else begin
                lcg_state      = lcg_next(lcg_state);
                stall_left     = lcg_state[17:16];
                waiting        = 1'b1;
                held_address   = address;
                held_writedata = writedata;
                held_read      = read;
                held_write     = write;
            end
            if (stall_left == 0) begin
                finish_transfer();
            end else begin
                stall_left--;
                waitrequest = 1'b1;
            end
        end else begin
            if (waiting) begin
                other_errors++;
                $display("strobe dropped before the transfer completed");
            end
            waiting     = 1'b0;
            waitrequest = 1'b1;
        end
    end

    initial begin
        loaded       = 1'b0;
        clk          = 1'b0;
        reset        = 1'b1;
        readdata     = '0;
        waitrequest  = 1'b1;
        lcg_state    = 32'h0a064498;
        waiting      = 1'b0;
        stall_left   = 0;
        stores_seen  = 0;
        value_errors = 0;
        other_errors = 0;
        $readmemh("sim/mips_tests.txt", tests);
        prog_len    = tests[0];
        store_count = tests[1];
        for (int i = 0; i < mem_words; i++) begin
            if (i < prog_len) begin
                mem[i] = tests[prog_base + i];
            end else begin
                mem[i] = 32'h5a5a_0000 ^ (i * 4);
            end
        end
        loaded = 1'b1;

        repeat (4) begin
            @(negedge clk);
            if (read || write || active) begin
                other_errors++;
                $display("read, write or active high during reset");
            end
        end
        reset = 1'b0;

        @(negedge clk);
        if (!active) begin
            other_errors++;
            $display("core did not become active after reset");
        end
        while (active) begin
            @(negedge clk);
        end

        // halted core must stay off the bus
        repeat (quiet_cycles) begin
            @(negedge clk);
            if (read || write || active) begin
                other_errors++;
                $display("bus activity or active high after halt");
            end
        end
        if (stores_seen != store_count) begin
            other_errors++;
            $display("saw %0d stores but expected %0d", stores_seen, store_count);
        end

        $display("errors: %0d mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog, four steps of up to five cycles per program word
    initial begin
        wait (loaded === 1'b1);
        watchdog_cycles = prog_len * 4 * 5 + 100;
        repeat (watchdog_cycles) @(posedge clk);
        $display("core did not halt within %0d clock cycles", watchdog_cycles);
        $display("errors: %0d mismatches, %0d other failures", value_errors, other_errors);
        $display("Something failed");
        $finish;
    end

endmodule

// File: sim/mips_tests.txt
// @00: program length in words, number of expected stores
// @10: program image, first word at address 0; @80: expected stores as address data pairs
@00
00000033 00000011
@10
// r10 = 0x200 store base, r1 = 0x1236, r2 = -3
240a0200 24011236 2402fffd
// addu and subu
00221821 ad430000 00222023 ad440004
// and, or
00222824 ad450008 00223025 ad46000c
// slt both ways
0041382a 0022402a ad470010 ad480014
// sll by 4, srl by 8
00014900 ad490018 00025a02 ad4b001c
// addiu negative, andi zero extended
242cf000 ad4c0020 304df0f0 ad4d0024
// ori zero extended, lui then ori
340e8001 ad4e0028 3c0fabcd 35ef5678 ad4f002c
// lw back and store again
8d50002c ad500030
// beq not taken, then beq taken over a store
10220001 ad410034 10630001 ad420038
// bne not taken, then bne taken over a store
14210001 ad430038 14220001 ad42003c
// j over two stores
08000029 ad420040 ad420044
// jr to word 44 over a store
241100b0 02200008 ad420040 ad440040
// loop three times with a backward bne, r19 = 15
24120003 26730005 2652ffff 1640fffd ad530044
// jr to address zero halts
00000008
@80
00000200 00001233
00000204 00001239
00000208 00001234
0000020c ffffffff
00000210 00000001
00000214 00000000
00000218 00012360
0000021c 00ffffff
00000220 00000236
00000224 0000f0f0
00000228 00008001
0000022c abcd5678
00000230 abcd5678
00000234 00001236
00000238 00001233
00000240 00001239
00000244 0000000f

// File: tb.f
rtl/mips_isa_pkg.sv
rtl/core_bus_pkg.sv
rtl/instr_reg.sv
rtl/cycle_ctrl.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/mips_core.sv
sim/tb_mips_core.sv
